// File: bench/clockGen.sv
// Testbench clock and reset source.
// 20 ns clock period; reset is high for the first 10 rising edges.
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        // Release away from the active edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/renameTb.sv
// Testbench for the rename stage with a cycle-level reference model.
// Inputs change on the falling edge; outputs are checked on the rising edge.
// Upstream holds decoded steady until a rising edge sees stallUpper low.
`timescale 1ns/1ps
`default_nettype none

module renameTb;

    typedef renamePkg::OpInfo [1:0]         OpGroup;
    typedef renamePkg::RenamedOp [1:0]      RenamedGroup;
    typedef renamePkg::ActiveListEntry [1:0] EntryGroup;

    localparam int PLANNED_GROUPS = 190;
    localparam int TIMEOUT_CYCLES = PLANNED_GROUPS * 40 + 500;

    logic clk, rst, dispatchStall, storeQueueEmpty, commit, stallUpper, commitValid;
    OpGroup decoded;
    RenamedGroup renamed;
    renamePkg::ActiveListEntry commitEntry;

    // Reference model state
    renamePkg::PhyRegNum       mapM [renamePkg::LOG_REG_NUM];
    renamePkg::PhyRegNum       freeQ [$];
    renamePkg::ActiveListEntry alQ [$];
    renamePkg::ActiveListPtr   alTail;
    OpGroup pipeM;
    logic phaseWait, accepted;
    int errors, resStalls, serStalls;
    logic [31:0] nextPc;

    clockGen clocks (.clk(clk), .rst(rst));

    renameStage u_dut (
        .clk(clk), .rst(rst), .decoded(decoded), .dispatchStall(dispatchStall),
        .storeQueueEmpty(storeQueueEmpty), .commit(commit), .renamed(renamed),
        .stallUpper(stallUpper), .commitValid(commitValid), .commitEntry(commitEntry)
    );

    task automatic compareRenamed(input string name, input renamePkg::RenamedOp exp,
                                  input renamePkg::RenamedOp act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compareEntry(input string name, input renamePkg::ActiveListEntry exp,
                                input renamePkg::ActiveListEntry act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compareBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic resetModel();
        for (int r = 0; r < renamePkg::LOG_REG_NUM; r++) begin
            mapM[r] = renamePkg::PhyRegNum'(r);
        end
        freeQ.delete();
        for (int r = renamePkg::LOG_REG_NUM; r < renamePkg::PHY_REG_NUM; r++) begin
            freeQ.push_back(renamePkg::PhyRegNum'(r));
        end
        alQ.delete();
        alTail    = '0;
        pipeM     = '0;
        phaseWait = 1'b0;
        accepted  = 1'b1;
    endtask

    // Expected renamed lanes and active-list records for the held group
    function automatic void predictGroup(input OpGroup grp, input logic stl,
                                         output RenamedGroup ren, output EntryGroup ent);
        renamePkg::PhyRegNum srcA, srcB, prev, dst0;
        renamePkg::ActiveListPtr slot;
        logic alloc, alloc0;
        int used;
        used   = 0;
        slot   = alTail;
        alloc0 = 1'b0;
        dst0   = '0;
        for (int i = 0; i < 2; i++) begin
            srcA = mapM[grp[i].srcRegA];
            srcB = mapM[grp[i].srcRegB];
            prev = mapM[grp[i].dstReg];
            if (i == 1 && alloc0) begin
                if (grp[0].dstReg == grp[1].srcRegA) srcA = dst0;
                if (grp[0].dstReg == grp[1].srcRegB) srcB = dst0;
                if (grp[0].dstReg == grp[1].dstReg) prev = dst0;
            end
            alloc = grp[i].valid && !stl && grp[i].writeReg;
            ren[i].valid         = grp[i].valid && !stl;
            ren[i].pc            = grp[i].pc;
            ren[i].opClass       = grp[i].opClass;
            ren[i].phySrcA       = grp[i].readRegA ? srcA : '0;
            ren[i].phySrcB       = grp[i].readRegB ? srcB : '0;
            ren[i].phyDst        = alloc ? freeQ[used] : '0;
            ren[i].phyPrevDst    = alloc ? prev : '0;
            ren[i].activeListPtr = slot;
            ent[i].pc         = grp[i].pc;
            ent[i].logDst     = grp[i].dstReg;
            ent[i].phyDst     = ren[i].phyDst;
            ent[i].phyPrevDst = ren[i].phyPrevDst;
            ent[i].writeReg   = grp[i].writeReg;
            ent[i].isLoad     = grp[i].opClass == renamePkg::OP_LOAD;
            ent[i].isStore    = grp[i].opClass == renamePkg::OP_STORE;
            ent[i].isBranch   = grp[i].opClass == renamePkg::OP_BRANCH;
            ent[i].serialized = grp[i].serialized;
            if (ren[i].valid) slot++;
            if (alloc) used++;
            if (i == 0) begin
                alloc0 = alloc;
                dst0   = ren[0].phyDst;
            end
        end
    endfunction

    task automatic checkCycle();
        RenamedGroup expRen;
        EntryGroup expEnt;
        logic ser, bubble, stl, cv, relValid;
        renamePkg::PhyRegNum relReg;
        ser = 1'b0;
        if (!phaseWait && pipeM[0].valid && pipeM[0].serialized) begin
            ser = alQ.size() != 0 || (pipeM[0].fence && !storeQueueEmpty);
        end else if (phaseWait) begin
            ser = alQ.size() != 0 || !storeQueueEmpty;
        end
        bubble = ser || ((pipeM[0].valid || pipeM[1].valid) &&
                 (freeQ.size() < 2 || renamePkg::ACTIVE_LIST_DEPTH - alQ.size() < 2));
        stl = dispatchStall || bubble;
        if (ser) serStalls++;
        if (bubble && !ser) resStalls++;
        predictGroup(pipeM, stl, expRen, expEnt);
        compareBit("stallUpper", stl, stallUpper);
        for (int i = 0; i < 2; i++) begin
            compareBit($sformatf("renamed[%0d].valid", i), expRen[i].valid, renamed[i].valid);
            if (expRen[i].valid) begin
                compareRenamed($sformatf("renamed[%0d]", i), expRen[i], renamed[i]);
            end
        end
        cv = commit && alQ.size() != 0;
        compareBit("commitValid", cv, commitValid);
        relValid = 1'b0;
        relReg   = '0;
        if (cv) begin
            compareEntry("commitEntry", alQ[0], commitEntry);
            relValid = alQ[0].writeReg;
            relReg   = alQ[0].phyPrevDst;
            void'(alQ.pop_front());
        end
        for (int i = 0; i < 2; i++) begin
            if (expRen[i].valid) begin
                alQ.push_back(expEnt[i]);
                alTail++;
            end
            if (expRen[i].valid && pipeM[i].writeReg) begin
                void'(freeQ.pop_front());
                mapM[pipeM[i].dstReg] = expRen[i].phyDst;
            end
        end
        if (relValid) freeQ.push_back(relReg);
        // A serialized op that issues opens the wait for its own commit
        if (!dispatchStall && !ser) begin
            phaseWait = pipeM[0].valid && pipeM[0].serialized;
        end
        if (!stl) pipeM = decoded;
        accepted = !stl;
    endtask

    always @(posedge clk) begin
        if (rst) resetModel();
        else checkCycle();
    end

    function automatic renamePkg::OpInfo randomOp(input bit allWrite);
        renamePkg::OpInfo op;
        op.valid      = $urandom_range(9) != 0;
        op.pc         = nextPc;
        op.opClass    = renamePkg::OpClass'($urandom_range(3));
        // Narrow register range so clashes happen often
        op.srcRegA    = renamePkg::LogRegNum'($urandom_range(15));
        op.srcRegB    = renamePkg::LogRegNum'($urandom_range(15));
        op.dstReg     = renamePkg::LogRegNum'($urandom_range(15));
        op.readRegA   = 1'($urandom_range(1));
        op.readRegB   = 1'($urandom_range(1));
        op.writeReg   = allWrite || $urandom_range(3) != 0;
        op.serialized = 1'b0;
        op.fence      = 1'b0;
        nextPc        = nextPc + 32'd4;
        return op;
    endfunction

    function automatic OpGroup makeGroup(input int serPct, input bit allWrite);
        OpGroup grp;
        grp[0] = randomOp(allWrite);
        grp[1] = randomOp(allWrite);
        if ($urandom_range(99) < serPct) begin
            // Serialized ops travel alone in lane 0
            grp[0].valid      = 1'b1;
            grp[0].serialized = 1'b1;
            grp[0].fence      = 1'($urandom_range(1));
            grp[1].valid      = 1'b0;
        end else begin
            if ($urandom_range(1) != 0) grp[1].srcRegA = grp[0].dstReg;
            if ($urandom_range(3) == 0) grp[1].dstReg = grp[0].dstReg;
        end
        return grp;
    endfunction

    task automatic driveGroups(input int groups, input int commitPct, input int serPct,
                               input int stallPct, input bit allWrite);
        int sent;
        int span;
        sent = 0;
        span = 0;
        while (sent < groups) begin
            @(negedge clk);
            if (accepted) begin
                decoded = makeGroup(serPct, allWrite);
                sent++;
            end
            commit          = $urandom_range(99) < commitPct;
            storeQueueEmpty = $urandom_range(3) != 0;
            if (span == 0 && $urandom_range(99) < stallPct) span = $urandom_range(8, 1);
            dispatchStall = span != 0;
            if (span != 0) span--;
        end
    endtask

    // Empties the pipe and the active list, then strobes commit on the empty list
    task automatic drain();
        do begin
            @(negedge clk);
            if (accepted) decoded = '0;
            commit          = 1'b1;
            dispatchStall   = 1'b0;
            storeQueueEmpty = 1'b1;
        end while (alQ.size() != 0 || pipeM[0].valid || pipeM[1].valid || decoded != '0);
        repeat (3) @(negedge clk);
    endtask

    task automatic fillResources();
        int cycles;
        cycles = 0;
        resStalls = 0;
        while (resStalls < 5 && cycles < 200) begin
            @(negedge clk);
            if (accepted) decoded = makeGroup(0, 1'b1);
            commit = 1'b0;
            cycles++;
        end
        if (resStalls < 5) begin
            errors++;
            $display("Resource stall did not occur with commits held off");
        end
    endtask

    initial begin
        void'($urandom(32'hc7028f7b));
        decoded         = '0;
        dispatchStall   = 1'b0;
        storeQueueEmpty = 1'b1;
        commit          = 1'b0;
        errors          = 0;
        serStalls       = 0;
        nextPc          = 32'h0000_1000;
        wait (rst == 1'b0);
        drain();
        driveGroups(60, 70, 0, 0, 1'b0);
        drain();
        fillResources();
        driveGroups(20, 80, 0, 0, 1'b1);
        drain();
        driveGroups(40, 60, 30, 0, 1'b0);
        drain();
        if (serStalls == 0) begin
            errors++;
            $display("Serialized ops never waited for older ops");
        end
        driveGroups(50, 70, 5, 20, 1'b0);
        drain();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/activeList.sv
// In-order list of issued ops, pushed per group and popped one per commit.
// A commit strobe on an empty list is dropped.
// Entry storage has no reset; only pointers and count are cleared.
`timescale 1ns/1ps
`default_nettype none

module activeList (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 commit,
    input  logic [renamePkg::RENAME_WIDTH-1:0]                   push,
    input  renamePkg::ActiveListEntry [renamePkg::RENAME_WIDTH-1:0] pushEntry,
    output renamePkg::ActiveListPtr [renamePkg::RENAME_WIDTH-1:0]   tailPtr,
    output logic                                                 allocatable,
    output logic                                                 empty,
    output logic                                                 commitValid,
    output renamePkg::ActiveListEntry                            commitEntry,
    output renamePkg::PhyRegNum                                  releaseReg,
    output logic                                                 releaseEn
);

    renamePkg::ActiveListEntry entries [renamePkg::ACTIVE_LIST_DEPTH];
    renamePkg::ActiveListPtr   head;
    renamePkg::ActiveListPtr   tail;
    renamePkg::ActiveListCount count;
    renamePkg::ActiveListCount numPush;

    // Slot of each pushing lane, packed behind the older lanes
    always_comb begin
        numPush = '0;
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            tailPtr[i] = renamePkg::ActiveListPtr'(tail + numPush);
            if (push[i]) begin
                numPush = numPush + 1'b1;
            end
        end
    end

    assign empty       = count == '0;
    assign allocatable = (renamePkg::ActiveListCount'(renamePkg::ACTIVE_LIST_DEPTH) - count)
                         >= renamePkg::ActiveListCount'(renamePkg::RENAME_WIDTH);

    // Commit side
    assign commitValid = commit && !empty;
    assign commitEntry = entries[head];
    assign releaseEn   = commitValid && commitEntry.writeReg;
    assign releaseReg  = commitEntry.phyPrevDst;

    always_ff @(posedge clk) begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            if (push[i]) begin
                entries[tailPtr[i]] <= pushEntry[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + renamePkg::ActiveListPtr'(numPush);
            head  <= head + renamePkg::ActiveListPtr'(commitValid);
            count <= count + numPush - renamePkg::ActiveListCount'(commitValid);
        end
    end

endmodule

`default_nettype wire

// File: logic/freeList.sv
// Circular queue of free physical registers.
// Starts full with registers LOG_REG_NUM and up, in ascending order.
// Lanes allocate in lane order; one register comes back per cycle.
`timescale 1ns/1ps
`default_nettype none

module freeList (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [renamePkg::RENAME_WIDTH-1:0]             allocate,
    input  logic                                           releaseEn,
    input  renamePkg::PhyRegNum                            releaseReg,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] allocatedReg,
    output logic                                           allocatable
);

    renamePkg::PhyRegNum     slots [renamePkg::FREE_LIST_DEPTH];
    renamePkg::FreeListPtr   head;
    renamePkg::FreeListPtr   tail;
    renamePkg::FreeListCount count;
    renamePkg::FreeListCount numAlloc;

    // Each allocating lane takes the next entry after the older lanes
    always_comb begin
        numAlloc = '0;
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            allocatedReg[i] = slots[renamePkg::FreeListPtr'(head + numAlloc)];
            if (allocate[i]) begin
                numAlloc = numAlloc + 1'b1;
            end
        end
    end

    assign allocatable = count >= renamePkg::FreeListCount'(renamePkg::RENAME_WIDTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < renamePkg::FREE_LIST_DEPTH; i++) begin
                slots[i] <= renamePkg::PhyRegNum'(renamePkg::LOG_REG_NUM + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= renamePkg::FreeListCount'(renamePkg::FREE_LIST_DEPTH);
        end else begin
            head  <= head + renamePkg::FreeListPtr'(numAlloc);
            count <= count - numAlloc + renamePkg::FreeListCount'(releaseEn);
            if (releaseEn) begin
                slots[tail] <= releaseReg;
                tail        <= tail + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/renameLane.sv
// One rename lane, purely combinational.
// Destination fields are zero unless the lane allocates.
`timescale 1ns/1ps
`default_nettype none

module renameLane (
    input  renamePkg::OpInfo          op,
    input  logic                      update,
    input  renamePkg::PhyRegNum       phySrcA,
    input  renamePkg::PhyRegNum       phySrcB,
    input  renamePkg::PhyRegNum       phyDst,
    input  renamePkg::PhyRegNum       phyPrevDst,
    input  renamePkg::ActiveListPtr   slotPtr,
    output renamePkg::RenamedOp       renamed,
    output renamePkg::ActiveListEntry entry,
    output logic                      allocReg
);

    renamePkg::PhyRegNum dstOut;
    renamePkg::PhyRegNum prevDstOut;

    assign allocReg   = op.valid && update && op.writeReg;
    assign dstOut     = allocReg ? phyDst : '0;
    assign prevDstOut = allocReg ? phyPrevDst : '0;

    always_comb begin
        renamed.valid         = op.valid && update;
        renamed.pc            = op.pc;
        renamed.opClass       = op.opClass;
        renamed.phySrcA       = phySrcA;
        renamed.phySrcB       = phySrcB;
        renamed.phyDst        = dstOut;
        renamed.phyPrevDst    = prevDstOut;
        renamed.activeListPtr = slotPtr;

        entry.pc         = op.pc;
        entry.logDst     = op.dstReg;
        entry.phyDst     = dstOut;
        entry.phyPrevDst = prevDstOut;
        entry.writeReg   = op.writeReg;
        // Class flags for commit
        entry.isLoad     = op.opClass == renamePkg::OP_LOAD;
        entry.isStore    = op.opClass == renamePkg::OP_STORE;
        entry.isBranch   = op.opClass == renamePkg::OP_BRANCH;
        entry.serialized = op.serialized;
    end

endmodule

`default_nettype wire

// File: logic/renameMapTable.sv
// Logical to physical register map, identity after reset.
// Reads are combinational from the register state with bypass from older lanes.
// On a destination clash within a group the youngest lane wins.
`timescale 1ns/1ps
`default_nettype none

module renameMapTable (
    input  logic                                           clk,
    input  logic                                           rst,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] srcRegA,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] srcRegB,
    input  renamePkg::LogRegNum [renamePkg::RENAME_WIDTH-1:0] dstReg,
    input  logic [renamePkg::RENAME_WIDTH-1:0]             readRegA,
    input  logic [renamePkg::RENAME_WIDTH-1:0]             readRegB,
    input  logic [renamePkg::RENAME_WIDTH-1:0]             writeEnable,
    input  renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] newDst,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcA,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phySrcB,
    output renamePkg::PhyRegNum [renamePkg::RENAME_WIDTH-1:0] phyPrevDst
);

    renamePkg::PhyRegNum mapReg [renamePkg::LOG_REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < renamePkg::LOG_REG_NUM; r++) begin
                mapReg[r] <= renamePkg::PhyRegNum'(r);
            end
        end else begin
            // Later lanes overwrite earlier ones
            for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
                if (writeEnable[i]) begin
                    mapReg[dstReg[i]] <= newDst[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < renamePkg::RENAME_WIDTH; i++) begin
            phySrcA[i]    = mapReg[srcRegA[i]];
            phySrcB[i]    = mapReg[srcRegB[i]];
            phyPrevDst[i] = mapReg[dstReg[i]];

            // Bypass from older lanes of the same group, youngest match last
            for (int j = 0; j < i; j++) begin
                if (writeEnable[j]) begin
                    if (dstReg[j] == srcRegA[i]) begin
                        phySrcA[i] = newDst[j];
                    end
                    if (dstReg[j] == srcRegB[i]) begin
                        phySrcB[i] = newDst[j];
                    end
                    if (dstReg[j] == dstReg[i]) begin
                        phyPrevDst[i] = newDst[j];
                    end
                end
            end

            // Unused sources read as zero
            if (!readRegA[i]) begin
                phySrcA[i] = '0;
            end
            if (!readRegB[i]) begin
                phySrcB[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/renamePkg.sv
// Shared sizes and records for the rename stage.
// Free list size is fixed to PHY_REG_NUM minus LOG_REG_NUM.
// Depths are powers of two so the queue pointers wrap by overflow.
`default_nettype none

package renamePkg;

    localparam int RENAME_WIDTH      = 2;
    localparam int LOG_REG_NUM       = 32;
    localparam int PHY_REG_NUM       = 64;
    localparam int FREE_LIST_DEPTH   = PHY_REG_NUM - LOG_REG_NUM;
    localparam int ACTIVE_LIST_DEPTH = 16;

    typedef logic [$clog2(LOG_REG_NUM)-1:0]       LogRegNum;
    typedef logic [$clog2(PHY_REG_NUM)-1:0]       PhyRegNum;
    typedef logic [$clog2(FREE_LIST_DEPTH)-1:0]   FreeListPtr;
    typedef logic [$clog2(FREE_LIST_DEPTH):0]     FreeListCount;
    typedef logic [$clog2(ACTIVE_LIST_DEPTH)-1:0] ActiveListPtr;
    typedef logic [$clog2(ACTIVE_LIST_DEPTH):0]   ActiveListCount;

    typedef enum logic [1:0] {
        OP_INT    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_LOAD   = 2'd2,
        OP_STORE  = 2'd3
    } OpClass;

    // Decoded op as delivered by decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        OpClass      opClass;
        LogRegNum    srcRegA;
        LogRegNum    srcRegB;
        LogRegNum    dstReg;
        logic        readRegA;
        logic        readRegB;
        logic        writeReg;
        logic        serialized;
        logic        fence;
    } OpInfo;

    // Renamed op toward dispatch
    typedef struct packed {
        logic         valid;
        logic [31:0]  pc;
        OpClass       opClass;
        PhyRegNum     phySrcA;
        PhyRegNum     phySrcB;
        PhyRegNum     phyDst;
        PhyRegNum     phyPrevDst;
        ActiveListPtr activeListPtr;
    } RenamedOp;

    typedef struct packed {
        logic [31:0] pc;
        LogRegNum    logDst;
        PhyRegNum    phyDst;
        PhyRegNum    phyPrevDst;
        logic        writeReg;
        logic        isLoad;
        logic        isStore;
        logic        isBranch;
        logic        serialized;
    } ActiveListEntry;

endpackage

`default_nettype wire

// File: logic/renameSerializer.sv
// Stalls the stage around serializing ops and fences.
// Only lane 0 of the held group is examined; decode sends such ops alone.
// The stall input must be the downstream stall only, not the bubble.
`timescale 1ns/1ps
`default_nettype none

module renameSerializer (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              activeListEmpty,
    input  logic              storeQueueEmpty,
    input  renamePkg::OpInfo  headOp,
    output logic              serialize
);

    typedef enum logic {
        PHASE_NORMAL,
        PHASE_WAIT_OWN
    } Phase;

    Phase phase;
    Phase nextPhase;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PHASE_NORMAL;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        serialize = 1'b0;
        nextPhase = phase;
        case (phase)
            PHASE_NORMAL: begin
                if (headOp.valid && headOp.serialized) begin
                    // Older ops first, and for a fence the store queue too
                    if (!activeListEmpty || (headOp.fence && !storeQueueEmpty)) begin
                        serialize = 1'b1;
                    end else begin
                        nextPhase = PHASE_WAIT_OWN;
                    end
                end
            end
            PHASE_WAIT_OWN: begin
                // Hold younger ops until the serialized op has left
                if (!activeListEmpty || !storeQueueEmpty) begin
                    serialize = 1'b1;
                end else if (!(headOp.valid && headOp.serialized)) begin
                    nextPhase = PHASE_NORMAL;
                end
                // A serialized op issuing here starts its own wait
            end
            default: nextPhase = PHASE_NORMAL;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/renameStage.sv
// Rename stage top: pipeline register, stall decision and rename structures.
// Upstream must hold decoded steady while stallUpper is high.
// No flush or branch recovery.
`timescale 1ns/1ps
`default_nettype none

module renameStage (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  renamePkg::OpInfo [renamePkg::RENAME_WIDTH-1:0]          decoded,
    input  logic                                                 dispatchStall,
    input  logic                                                 storeQueueEmpty,
    input  logic                                                 commit,
    output renamePkg::RenamedOp [renamePkg::RENAME_WIDTH-1:0]       renamed,
    output logic                                                 stallUpper,
    output logic                                                 commitValid,
    output renamePkg::ActiveListEntry                            commitEntry
);

    localparam int W = renamePkg::RENAME_WIDTH;

    renamePkg::OpInfo [W-1:0]         pipeReg;
    renamePkg::LogRegNum [W-1:0]      srcRegA, srcRegB, dstReg;
    logic [W-1:0]                     valid, readRegA, readRegB, update, allocReg;
    renamePkg::PhyRegNum [W-1:0]      phySrcA, phySrcB, phyPrevDst, newDst;
    renamePkg::ActiveListPtr [W-1:0]  tailPtr;
    renamePkg::ActiveListEntry [W-1:0] alEntry;
    renamePkg::PhyRegNum              releaseReg;
    logic releaseEn, freeAllocatable, alAllocatable, alEmpty, serialize, bubble, stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < W; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= decoded;
        end
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            valid[i]    = pipeReg[i].valid;
            srcRegA[i]  = pipeReg[i].srcRegA;
            srcRegB[i]  = pipeReg[i].srcRegB;
            dstReg[i]   = pipeReg[i].dstReg;
            readRegA[i] = pipeReg[i].readRegA;
            readRegB[i] = pipeReg[i].readRegB;
        end
        // Bubble when a full group cannot be allocated
        bubble     = serialize || (|valid && (!freeAllocatable || !alAllocatable));
        stall      = dispatchStall || bubble;
        stallUpper = stall;
        update     = valid & {W{!stall}};
    end

    renameSerializer serializer (
        .clk(clk), .rst(rst), .stall(dispatchStall), .activeListEmpty(alEmpty),
        .storeQueueEmpty(storeQueueEmpty), .headOp(pipeReg[0]), .serialize(serialize)
    );

    renameMapTable mapTable (
        .clk(clk), .rst(rst), .srcRegA(srcRegA), .srcRegB(srcRegB), .dstReg(dstReg),
        .readRegA(readRegA), .readRegB(readRegB), .writeEnable(allocReg), .newDst(newDst),
        .phySrcA(phySrcA), .phySrcB(phySrcB), .phyPrevDst(phyPrevDst)
    );

    freeList freeRegs (
        .clk(clk), .rst(rst), .allocate(allocReg), .releaseEn(releaseEn),
        .releaseReg(releaseReg), .allocatedReg(newDst), .allocatable(freeAllocatable)
    );

    activeList activeOps (
        .clk(clk), .rst(rst), .commit(commit), .push(update), .pushEntry(alEntry),
        .tailPtr(tailPtr), .allocatable(alAllocatable), .empty(alEmpty),
        .commitValid(commitValid), .commitEntry(commitEntry), .releaseReg(releaseReg),
        .releaseEn(releaseEn)
    );

    for (genvar i = 0; i < W; i++) begin : laneGen
        renameLane lane (
            .op(pipeReg[i]), .update(update[i]), .phySrcA(phySrcA[i]), .phySrcB(phySrcB[i]),
            .phyDst(newDst[i]), .phyPrevDst(phyPrevDst[i]), .slotPtr(tailPtr[i]),
            .renamed(renamed[i]), .entry(alEntry[i]), .allocReg(allocReg[i])
        );
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds and runs the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module renameTb \
    -Mdir obj_dir -o renameSim
./obj_dir/renameSim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// File: vlog.f
logic/renamePkg.sv
logic/renameSerializer.sv
logic/renameMapTable.sv
logic/freeList.sv
logic/renameLane.sv
logic/activeList.sv
logic/renameStage.sv
bench/clockGen.sv
bench/renameTb.sv
